// ==== src/masked_add_pkg.sv ====
/* Masked adder package
   Operand width, latency, Boolean share types and request/result structs */

`default_nettype none

package masked_add_pkg;

    // ==================================================================
    // Sizes
    // ==================================================================
    localparam int ADD_WIDTH   = 8;              // Operand width in bits
    localparam int ADD_LATENCY = ADD_WIDTH + 2;  // Operand regs to sum, in cycles

    // ==================================================================
    // Share types
    // ==================================================================

    // One bit in two Boolean shares, plain bit is s[1] ^ s[0]
    typedef logic [1:0] share_t;

    // Word of shared bits, element i carries plain bit i
    typedef share_t [ADD_WIDTH-1:0] masked_word_t;

    // ==================================================================
    // Request / result
    // ==================================================================
    typedef struct packed {
        masked_word_t         x;       // Operand x, two shares per bit
        masked_word_t         y;       // Operand y, two shares per bit
        logic [ADD_WIDTH-1:0] mask_x;  // Fresh mask for remasking x
        logic [ADD_WIDTH-1:0] mask_y;  // Fresh mask for remasking y
    } add_req_t;

    typedef struct packed {
        masked_word_t s;               // Sum mod 2^ADD_WIDTH, still shared
    } add_res_t;

endpackage : masked_add_pkg

`default_nettype wire

// ==== src/masked_full_adder.sv ====
/* Masked full adder, first order
   Share-wise XOR sum and DOM-AND majority carry, both registered */

`timescale 1ns/1ps
`default_nettype none

module masked_full_adder
    import masked_add_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   zeroize,
    input  share_t x,        // Operand bit, shared
    input  share_t y,        // Operand bit, shared
    input  share_t c_in,     // Carry in, shared
    input  logic   rnd,      // Fresh bit for the DOM cross terms
    output share_t s,        // Sum bit, one cycle later
    output share_t c_out     // Carry out, one cycle later
);

    share_t a;               // x ^ c, share-wise
    share_t b;               // y ^ c, share-wise
    share_t s_q;
    share_t c_q;             // Carry delayed to meet the gadget output
    logic   inner0_q;        // Domain 0 product a0 & b0
    logic   inner1_q;        // Domain 1 product a1 & b1
    logic   cross0_q;        // a0 & b1, refreshed
    logic   cross1_q;        // a1 & b0, refreshed

    // maj(x, y, c) = ((x ^ c) & (y ^ c)) ^ c
    assign a = x ^ c_in;
    assign b = y ^ c_in;

    // ==================================================================
    // Register stage, cross terms get rnd before the flop
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_q      <= '0;
            c_q      <= '0;
            inner0_q <= 1'b0;
            inner1_q <= 1'b0;
            cross0_q <= 1'b0;
            cross1_q <= 1'b0;
        end else if (zeroize) begin
            s_q      <= '0;
            c_q      <= '0;
            inner0_q <= 1'b0;
            inner1_q <= 1'b0;
            cross0_q <= 1'b0;
            cross1_q <= 1'b0;
        end else begin
            s_q      <= x ^ y ^ c_in;          // Linear, stays in its share
            c_q      <= c_in;
            inner0_q <= a[0] & b[0];
            inner1_q <= a[1] & b[1];
            cross0_q <= (a[0] & b[1]) ^ rnd;   // Same rnd in both, cancels on unmask
            cross1_q <= (a[1] & b[0]) ^ rnd;
        end
    end

    // Compression after the flops, then XOR c back in per share
    assign s     = s_q;
    assign c_out = {inner1_q ^ cross1_q ^ c_q[1],
                    inner0_q ^ cross0_q ^ c_q[0]};

endmodule : masked_full_adder

`default_nettype wire

// ==== src/masked_bool_adder.sv ====
/* Pipelined masked ripple-carry adder on Boolean shares
   Skewed operands meet the rippling carry, deskewed sums leave together */

`timescale 1ns/1ps
`default_nettype none

module masked_bool_adder
    import masked_add_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 zeroize,
    input  masked_word_t         x,      // Operand x, new pair accepted every cycle
    input  masked_word_t         y,      // Operand y
    input  logic [ADD_WIDTH-1:0] rnd,    // Bit i feeds full adder i
    output masked_word_t         s       // Sum, ADD_LATENCY cycles after x/y
);

    share_t carry  [ADD_WIDTH];          // carry[i] enters bit i
    share_t fa_sum [ADD_WIDTH];          // Per-bit sum, bit i valid i+2 cycles in
    share_t s_out  [ADD_WIDTH];          // Aligned outputs

    assign carry[0] = '0;                // No carry into bit 0

    // ==================================================================
    // Per-bit slice: skew chain, adder cell, deskew chain
    // ==================================================================
    for (genvar i = 0; i < ADD_WIDTH; i++) begin : gen_bit
        // Stage 0 is the operand register, stages 1..i add the skew
        share_t [i:0]             x_skew;
        share_t [i:0]             y_skew;
        // Bit i finishes early by ADD_WIDTH-1-i cycles, wait it out here
        share_t [ADD_WIDTH-1-i:0] s_deskew;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                x_skew <= '0;
                y_skew <= '0;
            end else if (zeroize) begin
                x_skew <= '0;
                y_skew <= '0;
            end else begin
                x_skew[0] <= x[i];
                y_skew[0] <= y[i];
                for (int j = 1; j <= i; j++) begin
                    x_skew[j] <= x_skew[j-1];
                    y_skew[j] <= y_skew[j-1];
                end
            end
        end

        if (i < ADD_WIDTH - 1) begin : gen_fa
            // Carry from bit i-1 arrives the same cycle as x_skew[i]
            masked_full_adder u_fa (
                .clk     (clk),
                .rst_n   (rst_n),
                .zeroize (zeroize),
                .x       (x_skew[i]),
                .y       (y_skew[i]),
                .c_in    (carry[i]),
                .rnd     (rnd[i]),
                .s       (fa_sum[i]),
                .c_out   (carry[i+1])
            );
        end else begin : gen_msb
            share_t msb_sum_q;           // Top bit, carry out dropped (mod 2^W)

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    msb_sum_q <= '0;
                end else if (zeroize) begin
                    msb_sum_q <= '0;
                end else begin
                    msb_sum_q <= x_skew[i] ^ y_skew[i] ^ carry[i];
                end
            end

            assign fa_sum[i] = msb_sum_q;
        end

        // Deskew, length shrinks as i grows
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                s_deskew <= '0;
            end else if (zeroize) begin
                s_deskew <= '0;
            end else begin
                s_deskew[0] <= fa_sum[i];
                for (int j = 1; j < ADD_WIDTH - i; j++) begin
                    s_deskew[j] <= s_deskew[j-1];
                end
            end
        end

        assign s_out[i] = s_deskew[ADD_WIDTH-1-i];
    end

    // ==================================================================
    // Output packing
    // ==================================================================
    always_comb begin
        for (int i = 0; i < ADD_WIDTH; i++) begin
            s[i] = s_out[i];
        end
    end

endmodule : masked_bool_adder

`default_nettype wire

// ==== src/share_refresh_stage.sv ====
/* Input refresh stage
   Captures a request on in_valid and remasks both operands with fresh masks */

`timescale 1ns/1ps
`default_nettype none

module share_refresh_stage
    import masked_add_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         zeroize,
    input  logic         in_valid,
    input  add_req_t     in_req,
    output masked_word_t op_x,       // Remasked x, held until next capture
    output masked_word_t op_y,       // Remasked y
    output logic         op_valid    // One-cycle strobe per capture
);

    // XOR mask bit i into both shares of bit i, plain value unchanged
    function automatic masked_word_t remask(input masked_word_t w,
                                            input logic [ADD_WIDTH-1:0] m);
        masked_word_t r;
        for (int i = 0; i < ADD_WIDTH; i++) begin
            r[i] = w[i] ^ {2{m[i]}};
        end
        return r;
    endfunction

    // ==================================================================
    // Capture registers
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_x     <= '0;
            op_y     <= '0;
            op_valid <= 1'b0;
        end else if (zeroize) begin
            op_x     <= '0;
            op_y     <= '0;
            op_valid <= 1'b0;
        end else begin
            op_valid <= in_valid;      // Pulse follows the strobe by one cycle
            if (in_valid) begin
                // Adder shares no longer match the caller's shares
                op_x <= remask(in_req.x, in_req.mask_x);
                op_y <= remask(in_req.y, in_req.mask_y);
            end
        end
    end

endmodule : share_refresh_stage

`default_nettype wire

// ==== src/share_result_stage.sv ====
/* Output result stage
   Delays the valid strobe by the adder latency and holds the last sum */

`timescale 1ns/1ps
`default_nettype none

module share_result_stage
    import masked_add_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         zeroize,
    input  logic         op_valid,   // Strobe alongside the adder operands
    input  masked_word_t sum,        // Adder output, ADD_LATENCY behind op_valid
    output logic         out_valid,
    output add_res_t     out_res     // Held until the next out_valid
);

    logic [ADD_LATENCY-1:0] valid_dly;   // Tracks in-flight additions

    // ==================================================================
    // Valid delay line and result hold register
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_dly <= '0;
            out_valid <= 1'b0;
            out_res   <= '0;
        end else if (zeroize) begin
            // Drops everything in flight
            valid_dly <= '0;
            out_valid <= 1'b0;
            out_res   <= '0;
        end else begin
            valid_dly <= {valid_dly[ADD_LATENCY-2:0], op_valid};
            out_valid <= valid_dly[ADD_LATENCY-1];
            // Top stage high means sum carries that request now
            if (valid_dly[ADD_LATENCY-1]) begin
                out_res.s <= sum;
            end
        end
    end

endmodule : share_result_stage

`default_nettype wire

// ==== src/masked_add_top.sv ====
/* Masked adder top level
   Refresh stage, pipelined masked adder and result stage in series */

`timescale 1ns/1ps
`default_nettype none

module masked_add_top
    import masked_add_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 zeroize,   // Synchronous wipe of all shares
    input  logic                 in_valid,
    input  add_req_t             in_req,
    input  logic [ADD_WIDTH-1:0] rnd,       // From TRNG, new every cycle
    output logic                 out_valid, // ADD_LATENCY+1 cycles after in_valid
    output add_res_t             out_res
);

    masked_word_t op_x;
    masked_word_t op_y;
    logic         op_valid;
    masked_word_t sum;

    // ==================================================================
    // Datapath
    // ==================================================================
    share_refresh_stage u_refresh (
        .clk      (clk),
        .rst_n    (rst_n),
        .zeroize  (zeroize),
        .in_valid (in_valid),
        .in_req   (in_req),
        .op_x     (op_x),
        .op_y     (op_y),
        .op_valid (op_valid)
    );

    masked_bool_adder u_adder (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .x       (op_x),
        .y       (op_y),
        .rnd     (rnd),
        .s       (sum)
    );

    share_result_stage u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize   (zeroize),
        .op_valid  (op_valid),
        .sum       (sum),
        .out_valid (out_valid),
        .out_res   (out_res)
    );

endmodule : masked_add_top

`default_nettype wire

// ==== verification/masked_add_tb.sv ====
/* Masked adder testbench
   Directed tests on shared operands, unmasked results checked against a plain sum */

`timescale 1ns/1ps
`default_nettype none

module masked_add_tb
    import masked_add_pkg::*;
();

    // ==================================================================
    // Timing and run length
    // ==================================================================
    localparam int CLK_PERIOD = 4;                  // ns
    localparam int OUT_DELAY  = ADD_LATENCY + 1;    // Sampling edge to out_valid
    localparam int WAIT_LIMIT = 2 * OUT_DELAY;      // Give up on a result after this
    localparam int N_SINGLE   = 20;
    localparam int N_STREAM   = 16;
    localparam int N_REQUESTS = N_SINGLE + 4 + N_STREAM + 5 + 2;
    localparam int N_TESTS    = 6;
    localparam int WATCHDOG_NS = (N_REQUESTS + OUT_DELAY * N_TESTS) * 4 * CLK_PERIOD;

    logic                 clk;
    logic                 rst_n;
    logic                 zeroize;
    logic                 in_valid;
    add_req_t             in_req;
    logic [ADD_WIDTH-1:0] rnd;
    logic                 out_valid;
    add_res_t             out_res;

    int          value_errs    = 0;    // Wrong data or latency
    int          protocol_errs = 0;    // Missing or stray strobes
    logic [31:0] lcg_state     = 32'd75320;

    masked_add_top masked_add_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize   (zeroize),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .rnd       (rnd),
        .out_valid (out_valid),
        .out_res   (out_res)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================================
    // Stimulus helpers
    // ==================================================================
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [ADD_WIDTH-1:0] rand_word();
        logic [31:0] r;
        r = next_random();
        return r[31 -: ADD_WIDTH];     // High bits have the longest period
    endfunction

    // Plain bit i is the XOR of its two shares
    function automatic logic [ADD_WIDTH-1:0] unmask(input masked_word_t w);
        logic [ADD_WIDTH-1:0] v;
        for (int i = 0; i < ADD_WIDTH; i++) begin
            v[i] = w[i][1] ^ w[i][0];
        end
        return v;
    endfunction

    // Split plain operands into random shares, fresh remask words on top
    function automatic add_req_t make_req(input logic [ADD_WIDTH-1:0] px,
                                          input logic [ADD_WIDTH-1:0] py);
        add_req_t             r;
        logic [ADD_WIDTH-1:0] mx;
        logic [ADD_WIDTH-1:0] my;
        mx = rand_word();
        my = rand_word();
        for (int i = 0; i < ADD_WIDTH; i++) begin
            r.x[i] = {mx[i], px[i] ^ mx[i]};
            r.y[i] = {my[i], py[i] ^ my[i]};
        end
        r.mask_x = rand_word();
        r.mask_y = rand_word();
        return r;
    endfunction

    // Reference result, wraps mod 2^ADD_WIDTH through the return width
    function automatic logic [ADD_WIDTH-1:0] ref_sum(input add_req_t r);
        logic [ADD_WIDTH-1:0] s;
        s = unmask(r.x) + unmask(r.y);
        return s;
    endfunction

    // Falling edge, new TRNG word every cycle
    task automatic tick();
        @(negedge clk);
        rnd = rand_word();
    endtask

    // ==================================================================
    // Checks
    // ==================================================================
    task automatic compare_res(input string name, input add_res_t act,
                               input logic [ADD_WIDTH-1:0] exp);
        logic [ADD_WIDTH-1:0] got;
        got = unmask(act.s);
        if (got !== exp) begin
            $display("ERROR %s: expected 0x%02h, actual 0x%02h at %0t", name, exp, got, $time);
            value_errs++;
        end
    endtask

    task automatic compare_valid(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("ERROR %s: expected out_valid %b, actual %b at %0t", name, exp, act, $time);
            value_errs++;
        end
    endtask

    task automatic check_strobe(input string name, input logic expected);
        if (out_valid !== expected) begin
            if (expected)
                $display("%s: out_valid missing at %0t", name, $time);
            else
                $display("%s: out_valid seen when no result was due at %0t", name, $time);
            protocol_errs++;
        end
    endtask

    // One request, then wait for its strobe and check latency and sum
    task automatic add_once(input string name, input add_req_t req, output add_res_t res);
        logic [ADD_WIDTH-1:0] exp;
        int                   cycles;
        exp = ref_sum(req);
        res = '0;
        tick();
        check_strobe(name, 1'b0);      // Previous pulse is one cycle wide
        in_req   = req;
        in_valid = 1'b1;
        tick();
        in_valid = 1'b0;
        for (cycles = 0; cycles < WAIT_LIMIT && out_valid !== 1'b1; cycles++) begin
            tick();
        end
        if (out_valid !== 1'b1) begin
            $display("%s: no out_valid within %0d cycles of the request", name, WAIT_LIMIT);
            protocol_errs++;
        end else begin
            if (cycles != OUT_DELAY) begin
                $display("ERROR %s latency: expected %0d, actual %0d", name, OUT_DELAY, cycles);
                value_errs++;
            end
            compare_res(name, out_res, exp);
            res = out_res;
        end
    endtask

    // ==================================================================
    // Directed tests
    // ==================================================================
    task automatic test_reset();
        tick();
        compare_valid("reset", out_valid, 1'b0);
        compare_res("reset", out_res, '0);
    endtask

    task automatic test_single();
        add_res_t res;
        for (int k = 0; k < N_SINGLE; k++) begin
            add_once($sformatf("single_%0d", k), make_req(rand_word(), rand_word()), res);
        end
    endtask

    task automatic test_edges();
        logic [ADD_WIDTH-1:0] ex [4] = '{8'h00, 8'hFF, 8'hFF, 8'h80};
        logic [ADD_WIDTH-1:0] ey [4] = '{8'h00, 8'h01, 8'hFF, 8'h80};
        add_res_t             res;
        for (int k = 0; k < 4; k++) begin
            add_once($sformatf("edge_%0d", k), make_req(ex[k], ey[k]), res);
        end
    endtask

    // Request t shows up at tick t + OUT_DELAY + 1, one per cycle
    task automatic test_stream();
        add_req_t             reqs [N_STREAM];
        logic [ADD_WIDTH-1:0] exp_q [$];
        int                   first;
        logic                 due;
        first = OUT_DELAY + 1;
        for (int k = 0; k < N_STREAM; k++) begin
            reqs[k] = make_req(rand_word(), rand_word());
            exp_q.push_back(ref_sum(reqs[k]));
        end
        for (int t = 0; t < N_STREAM + OUT_DELAY + 3; t++) begin
            tick();
            due = (t >= first) && (t < first + N_STREAM);
            check_strobe("stream", due);
            if (due && out_valid === 1'b1)
                compare_res($sformatf("stream_%0d", t - first), out_res, exp_q[t - first]);
            if (t < N_STREAM) begin
                in_req   = reqs[t];
                in_valid = 1'b1;
            end else begin
                in_valid = 1'b0;
            end
        end
    endtask

    task automatic test_zeroize();
        add_res_t res;
        for (int k = 0; k < 4; k++) begin
            tick();
            check_strobe("zeroize", 1'b0);
            in_req   = make_req(rand_word(), rand_word());
            in_valid = 1'b1;
        end
        tick();
        in_valid = 1'b0;
        zeroize  = 1'b1;               // Wipes the 4 requests in flight
        tick();
        zeroize  = 1'b0;
        for (int k = 0; k < OUT_DELAY + 2; k++) begin
            tick();
            check_strobe("zeroize", 1'b0);
        end
        compare_valid("zeroize", out_valid, 1'b0);
        compare_res("zeroize", out_res, '0);
        add_once("zeroize_after", make_req(rand_word(), rand_word()), res);
    endtask

    // Same plain pair, different shares and masks
    task automatic test_remask();
        logic [ADD_WIDTH-1:0] px;
        logic [ADD_WIDTH-1:0] py;
        logic [ADD_WIDTH-1:0] plain_sum;
        add_res_t             res_a;
        add_res_t             res_b;
        px        = rand_word();
        py        = rand_word();
        plain_sum = px + py;           // Wraps mod 2^ADD_WIDTH
        add_once("remask_a", make_req(px, py), res_a);
        add_once("remask_b", make_req(px, py), res_b);
        // Both share sets unmask to the same plain sum
        compare_res("remask_pair_a", res_a, plain_sum);
        compare_res("remask_pair_b", res_b, plain_sum);
    endtask

    // ==================================================================
    // Run control
    // ==================================================================
    initial begin
        rst_n    = 1'b0;
        zeroize  = 1'b0;
        in_valid = 1'b0;
        in_req   = '0;
        rnd      = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_single();
        test_edges();
        test_stream();
        test_zeroize();
        test_remask();

        $display("Errors: %0d value, %0d protocol", value_errs, protocol_errs);
        if (value_errs + protocol_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run still going after %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule : masked_add_tb

`default_nettype wire

// ==== build.f ====
src/masked_add_pkg.sv
src/masked_full_adder.sv
src/masked_bool_adder.sv
src/share_refresh_stage.sv
src/share_result_stage.sv
src/masked_add_top.sv
verification/masked_add_tb.sv

// ==== Bender.yml ====
package:
  name: masked_add

sources:
  - files:
      - src/masked_add_pkg.sv
      - src/masked_full_adder.sv
      - src/masked_bool_adder.sv
      - src/share_refresh_stage.sv
      - src/share_result_stage.sv
      - src/masked_add_top.sv
  - target: test
    files:
      - verification/masked_add_tb.sv
